//--- hdl/rv_config.svh
// Core configuration macros: reset PC, data memory depth, instruction width
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// First fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// Data memory depth in 64-bit doublewords, power of two
`define RV_DMEM_WORDS 256

// Instruction word width
`define RV_INSTR_WIDTH 32

`endif

//--- hdl/rvPkg.sv
// Shared types: data and index vectors, class and phase enums, decode and commit structs
`default_nettype none
`include "rv_config.svh"

package rvPkg;

  typedef logic [63:0] xlenT;
  typedef logic [`RV_INSTR_WIDTH-1:0] instrT;
  typedef logic [4:0] regIdxT;

  // Instruction classes seen by the execute blocks
  typedef enum logic [3:0] {
    OpReg,
    OpImm,
    OpRegW,
    OpImmW,
    Lui,
    Auipc,
    Load,
    Store,
    Branch,
    Jal,
    Jalr,
    Ebreak,
    Illegal
  } opClassT;

  // One instruction takes exactly these four steps
  typedef enum logic [1:0] {
    Fetch,
    Read,
    Execute,
    Writeback
  } phaseT;

  typedef struct packed {
    opClassT    opClass;
    logic [2:0] funct3;
    logic       funct7b5;
    regIdxT     rs1;
    regIdxT     rs2;
    regIdxT     rd;
    xlenT       imm;
    logic       writesRd;
  } decodeT;

  // Retirement record, one per instruction
  typedef struct packed {
    xlenT   pc;
    xlenT   nextPc;
    instrT  instr;
    logic   rdWe;
    regIdxT rd;
    xlenT   rdData;
  } commitT;

endpackage

`default_nettype wire

//--- hdl/rvDecode.sv
// Instruction decoder: opcode classification, register fields, immediate generation
`default_nettype none

module rvDecode import rvPkg::*; (
  input  instrT  instr,
  output decodeT dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  xlenT immI;
  xlenT immS;
  xlenT immB;
  xlenT immU;
  xlenT immJ;
  opClassT opClass;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  // Immediate formats, all sign-extended from bit 31
  assign immI = {{52{instr[31]}}, instr[31:20]};
  assign immS = {{52{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {{32{instr[31]}}, instr[31:12], 12'b0};
  assign immJ = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    unique case (opcode)
      7'b0110011: opClass = OpReg;
      7'b0010011: opClass = OpImm;
      7'b0111011: opClass = OpRegW;
      7'b0011011: opClass = OpImmW;
      7'b0110111: opClass = Lui;
      7'b0010111: opClass = Auipc;
      // Only word and doubleword accesses exist
      7'b0000011: opClass = (funct3 == 3'b010 || funct3 == 3'b011) ? Load : Illegal;
      7'b0100011: opClass = (funct3 == 3'b010 || funct3 == 3'b011) ? Store : Illegal;
      7'b1100011: opClass = Branch;
      7'b1101111: opClass = Jal;
      7'b1100111: opClass = Jalr;
      7'b1110011: opClass = (instr == 32'h0010_0073) ? Ebreak : Illegal;
      default:    opClass = Illegal;
    endcase
  end

  always_comb begin
    dec.opClass  = opClass;
    dec.funct3   = funct3;
    dec.funct7b5 = instr[30];
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.rd       = instr[11:7];

    unique case (opClass)
      Store:       dec.imm = immS;
      Branch:      dec.imm = immB;
      Lui, Auipc:  dec.imm = immU;
      Jal:         dec.imm = immJ;
      default:     dec.imm = immI;
    endcase

    // x0 as destination counts as no write
    unique case (opClass)
      OpReg, OpImm, OpRegW, OpImmW, Lui, Auipc, Load, Jal, Jalr:
        dec.writesRd = (instr[11:7] != 5'd0);
      default:
        dec.writesRd = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rvRegFile.sv
// Integer register file: 32 x 64 bits, two async reads, one sync write
`default_nettype none

module rvRegFile import rvPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  regIdxT rs1,
  input  regIdxT rs2,
  output xlenT   rs1Data,
  output xlenT   rs2Data,
  input  logic   we,
  input  regIdxT rd,
  input  xlenT   rdData
);

  xlenT regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rdData;
    end
  end

  // x0 is cleared at reset and never written
  assign rs1Data = regs[rs1];
  assign rs2Data = regs[rs2];

endmodule

`default_nettype wire

//--- hdl/rvAlu.sv
// Arithmetic and logic unit, also forms load and store addresses
`default_nettype none

module rvAlu import rvPkg::*; (
  input  decodeT dec,
  input  xlenT   pc,
  input  xlenT   rs1Data,
  input  xlenT   rs2Data,
  output xlenT   aluResult
);

  xlenT opA;
  xlenT opB;
  xlenT addSub;
  logic useSub;
  logic regForm;
  logic [31:0] wordRes;

  assign regForm = (dec.opClass == OpReg) || (dec.opClass == OpRegW);

  // auipc adds to the pc, everything else to rs1
  assign opA = (dec.opClass == Auipc) ? pc : rs1Data;
  assign opB = regForm ? rs2Data : dec.imm;

  // Bit 30 is an immediate bit for addi, so sub only in register forms
  assign useSub  = regForm && dec.funct7b5;
  assign addSub  = useSub ? (opA - opB) : (opA + opB);
  assign wordRes = addSub[31:0];

  always_comb begin
    unique case (dec.opClass)
      Lui: aluResult = dec.imm;
      OpRegW, OpImmW: aluResult = {{32{wordRes[31]}}, wordRes};
      OpReg, OpImm: begin
        unique case (dec.funct3)
          3'b000: aluResult = addSub;
          3'b001: aluResult = opA << opB[5:0];
          3'b010: aluResult = {63'b0, $signed(opA) < $signed(opB)};
          3'b011: aluResult = {63'b0, opA < opB};
          3'b100: aluResult = opA ^ opB;
          3'b101: begin
            if (dec.funct7b5) begin
              aluResult = xlenT'($signed(opA) >>> opB[5:0]);
            end else begin
              aluResult = opA >> opB[5:0];
            end
          end
          3'b110: aluResult = opA | opB;
          default: aluResult = opA & opB;
        endcase
      end
      // Loads, stores and auipc all need the plain sum
      default: aluResult = addSub;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rvBranchUnit.sv
// Branch condition evaluation and next-PC selection
`default_nettype none

module rvBranchUnit import rvPkg::*; (
  input  decodeT dec,
  input  xlenT   pc,
  input  xlenT   rs1Data,
  input  xlenT   rs2Data,
  output xlenT   nextPc,
  output xlenT   linkPc
);

  logic taken;
  xlenT pcTarget;
  xlenT regTarget;

  always_comb begin
    unique case (dec.funct3)
      3'b000:  taken = (rs1Data == rs2Data);
      3'b001:  taken = (rs1Data != rs2Data);
      3'b100:  taken = ($signed(rs1Data) < $signed(rs2Data));
      3'b101:  taken = ($signed(rs1Data) >= $signed(rs2Data));
      3'b110:  taken = (rs1Data < rs2Data);
      3'b111:  taken = (rs1Data >= rs2Data);
      default: taken = 1'b0;
    endcase
  end

  assign linkPc    = pc + 64'd4;
  assign pcTarget  = pc + dec.imm;
  // jalr drops bit 0 of the sum
  assign regTarget = (rs1Data + dec.imm) & ~64'd1;

  always_comb begin
    unique case (dec.opClass)
      Jal:     nextPc = pcTarget;
      Jalr:    nextPc = regTarget;
      Branch:  nextPc = taken ? pcTarget : linkPc;
      default: nextPc = linkPc;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rvDataMem.sv
// Data memory: doubleword array, registered read, word or doubleword write
`default_nettype none
`include "rv_config.svh"

module rvDataMem import rvPkg::*; (
  input  logic   clk,
  input  phaseT  phase,
  input  decodeT dec,
  input  xlenT   addr,
  input  xlenT   storeData,
  output xlenT   loadData
);

  localparam int IdxW = $clog2(`RV_DMEM_WORDS);

  xlenT mem [`RV_DMEM_WORDS];
  logic [IdxW-1:0] idx;
  logic upperHalf;
  logic isWord;
  xlenT rdWord;
  logic [31:0] rdHalf;

  // Address wraps modulo the depth
  assign idx       = addr[3 +: IdxW];
  assign upperHalf = addr[2];
  assign isWord    = (dec.funct3 == 3'b010);
  assign rdWord    = mem[idx];
  assign rdHalf    = upperHalf ? rdWord[63:32] : rdWord[31:0];

  always_ff @(posedge clk) begin
    if (phase == Execute && dec.opClass == Load) begin
      loadData <= isWord ? {{32{rdHalf[31]}}, rdHalf} : rdWord;
    end
    if (phase == Writeback && dec.opClass == Store) begin
      if (!isWord) begin
        mem[idx] <= storeData;
      end else if (upperHalf) begin
        mem[idx][63:32] <= storeData[31:0];
      end else begin
        mem[idx][31:0] <= storeData[31:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rvControl.sv
// Phase FSM, PC and instruction registers, writeback select, commit record and halt
`default_nettype none
`include "rv_config.svh"

module rvControl import rvPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  decodeT dec,
  input  instrT  instr,
  input  xlenT   aluResult,
  input  xlenT   loadData,
  input  xlenT   nextPc,
  input  xlenT   linkPc,
  output phaseT  phase,
  output xlenT   pc,
  output instrT  instrReg,
  output logic   rdWe,
  output xlenT   rdData,
  output logic   commitValid,
  output commitT commit,
  output logic   halted
);

  phaseT phaseNext;

  always_comb begin
    unique case (phase)
      Fetch:   phaseNext = Read;
      Read:    phaseNext = Execute;
      Execute: phaseNext = Writeback;
      default: phaseNext = Fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase  <= Fetch;
      pc     <= xlenT'(`RV_RESET_PC);
      halted <= 1'b0;
    end else if (!halted) begin
      // An ebreak retires and leaves the FSM parked in Fetch
      phase <= phaseNext;
      if (phase == Writeback) begin
        pc <= nextPc;
        if (dec.opClass == Ebreak) begin
          halted <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (phase == Fetch && !halted) begin
      instrReg <= instr;
    end
  end

  // Writeback value
  always_comb begin
    unique case (dec.opClass)
      Load:      rdData = loadData;
      Jal, Jalr: rdData = linkPc;
      default:   rdData = aluResult;
    endcase
  end

  assign commitValid = (phase == Writeback);
  assign rdWe        = commitValid && dec.writesRd;

  always_comb begin
    commit.pc     = pc;
    commit.nextPc = nextPc;
    commit.instr  = instrReg;
    commit.rdWe   = rdWe;
    commit.rd     = dec.rd;
    commit.rdData = rdData;
  end

endmodule

`default_nettype wire

//--- hdl/rvCpu.sv
// Core top level: control, decode, register file, ALU, branch unit, data memory
`default_nettype none

module rvCpu import rvPkg::*; (
  input  logic   clk,
  input  logic   rst,
  output xlenT   instrAddr,
  input  instrT  instr,
  output logic   commitValid,
  output commitT commit,
  output logic   halted
);

  phaseT  phase;
  xlenT   pc;
  instrT  instrReg;
  decodeT dec;
  xlenT   rs1Data;
  xlenT   rs2Data;
  xlenT   aluResult;
  xlenT   nextPc;
  xlenT   linkPc;
  xlenT   loadData;
  logic   rdWe;
  xlenT   rdData;

  assign instrAddr = pc;

  rvControl uControl (
    .clk(clk), .rst(rst), .dec(dec), .instr(instr),
    .aluResult(aluResult), .loadData(loadData), .nextPc(nextPc), .linkPc(linkPc),
    .phase(phase), .pc(pc), .instrReg(instrReg), .rdWe(rdWe), .rdData(rdData),
    .commitValid(commitValid), .commit(commit), .halted(halted)
  );

  rvDecode uDecode (.instr(instrReg), .dec(dec));

  rvRegFile uRegFile (
    .clk(clk), .rst(rst), .rs1(dec.rs1), .rs2(dec.rs2),
    .rs1Data(rs1Data), .rs2Data(rs2Data), .we(rdWe), .rd(dec.rd), .rdData(rdData)
  );

  rvAlu uAlu (
    .dec(dec), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .aluResult(aluResult)
  );

  rvBranchUnit uBranch (
    .dec(dec), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
    .nextPc(nextPc), .linkPc(linkPc)
  );

  rvDataMem uDataMem (
    .clk(clk), .phase(phase), .dec(dec), .addr(aluResult),
    .storeData(rs2Data), .loadData(loadData)
  );

endmodule

`default_nettype wire

//--- bench/rvCommitChecker.sv
// Commit checker: instruction-set reference model, commit comparison, timing and halt checks
`default_nettype none
`include "rv_config.svh"

module rvCommitChecker import rvPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  xlenT   instrAddr,
  input  instrT  instr,
  input  logic   commitValid,
  input  commitT commit,
  input  logic   halted,
  output int     valueErrors,
  output int     protocolErrors,
  output int     commitCount
);
  timeunit 1ns;
  timeprecision 1ps;

  xlenT refRegs [32];
  xlenT refMem [`RV_DMEM_WORDS];
  xlenT modelPc;
  commitT expected;
  int sinceRst;
  int sinceCommit;
  logic ebreakSeen;
  logic sawHalt;

  // One instruction on the software model, returns the expected commit
  function automatic commitT refStep(xlenT pc, instrT ins);
    commitT c;
    xlenT a;
    xlenT b;
    xlenT immI;
    xlenT immS;
    xlenT addr;
    xlenT res;
    logic [31:0] w;
    logic wr;
    logic take;
    int idx;
    a = refRegs[ins[19:15]];
    b = refRegs[ins[24:20]];
    immI = {{52{ins[31]}}, ins[31:20]};
    immS = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    res = '0;
    wr = 1'b1;
    c.pc = pc;
    c.instr = ins;
    c.nextPc = pc + 4;
    case (ins[6:0])
      7'b0110011, 7'b0010011: begin
        if (ins[6:0] == 7'b0010011) b = immI;
        case (ins[14:12])
          3'b000: res = (ins[5] && ins[30]) ? a - b : a + b;
          3'b001: res = a << b[5:0];
          3'b010: res = xlenT'($signed(a) < $signed(b));
          3'b011: res = xlenT'(a < b);
          3'b100: res = a ^ b;
          3'b110: res = a | b;
          default: res = a & b;
        endcase
      end
      7'b0111011, 7'b0011011: begin
        w = (ins[6:0] == 7'b0111011) ? a[31:0] + b[31:0] : a[31:0] + immI[31:0];
        res = {{32{w[31]}}, w};
      end
      7'b0110111: res = {{32{ins[31]}}, ins[31:12], 12'b0};
      7'b0010111: res = pc + {{32{ins[31]}}, ins[31:12], 12'b0};
      7'b0000011: begin
        addr = a + immI;
        idx = int'((addr >> 3) % `RV_DMEM_WORDS);
        w = addr[2] ? refMem[idx][63:32] : refMem[idx][31:0];
        res = (ins[14:12] == 3'b010) ? {{32{w[31]}}, w} : refMem[idx];
      end
      7'b0100011: begin
        wr = 1'b0;
        addr = a + immS;
        idx = int'((addr >> 3) % `RV_DMEM_WORDS);
        if (ins[14:12] == 3'b011) refMem[idx] = b;
        else if (addr[2]) refMem[idx][63:32] = b[31:0];
        else refMem[idx][31:0] = b[31:0];
      end
      7'b1100011: begin
        wr = 1'b0;
        case (ins[14:12])
          3'b000: take = (a == b);
          3'b001: take = (a != b);
          3'b100: take = $signed(a) < $signed(b);
          3'b101: take = $signed(a) >= $signed(b);
          3'b110: take = a < b;
          default: take = a >= b;
        endcase
        if (take) c.nextPc = pc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      7'b1101111: begin
        res = pc + 4;
        c.nextPc = pc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b1100111: begin
        res = pc + 4;
        c.nextPc = (a + immI) & ~64'd1;
      end
      default: wr = 1'b0;
    endcase
    c.rdWe = wr && (ins[11:7] != 5'd0);
    c.rd = ins[11:7];
    c.rdData = res;
    if (c.rdWe) refRegs[ins[11:7]] = res;
    return c;
  endfunction

  task automatic fieldCheck(string name, xlenT got, xlenT want);
    if (got !== want) begin
      valueErrors++;
      $display("FAIL %0t: %s got %h, expected %h (pc %h)", $time, name, got, want, modelPc);
    end
  endtask

  task automatic protocolError(string msg);
    protocolErrors++;
    $display("Protocol error at %0t: %s", $time, msg);
  endtask

  initial begin
    valueErrors = 0;
    protocolErrors = 0;
    commitCount = 0;
    modelPc = xlenT'(`RV_RESET_PC);
    ebreakSeen = 1'b0;
    sawHalt = 1'b0;
    for (int i = 0; i < 32; i++) refRegs[i] = '0;
  end

  // Sampled at the falling edge, away from register updates
  always @(negedge clk) begin
    if (rst) begin
      sinceRst = 0;
      sinceCommit = 0;
    end else begin
      sinceRst++;
      sinceCommit++;
      if (sinceRst == 1 && (commitValid !== 1'b0 || halted !== 1'b0))
        protocolError("commitValid or halted high right after reset");
      if (sawHalt && halted !== 1'b1) protocolError("halted dropped after rising");
      // The fetch address follows the model pc until the next commit
      fieldCheck("instrAddr", instrAddr, modelPc);
      if (commitValid === 1'b1) begin
        if (sawHalt) protocolError("commit seen after halt");
        if (commitCount == 0 && sinceRst != 4)
          protocolError("first commit not in the fourth cycle after reset");
        if (commitCount > 0 && sinceCommit != 4)
          protocolError("commits not four cycles apart");
        expected = refStep(modelPc, instr);
        fieldCheck("pc", commit.pc, expected.pc);
        fieldCheck("nextPc", commit.nextPc, expected.nextPc);
        fieldCheck("instr", xlenT'(commit.instr), xlenT'(expected.instr));
        fieldCheck("rdWe", xlenT'(commit.rdWe), xlenT'(expected.rdWe));
        if (expected.rdWe) begin
          fieldCheck("rd", xlenT'(commit.rd), xlenT'(expected.rd));
          fieldCheck("rdData", commit.rdData, expected.rdData);
        end
        if (instr == 32'h0010_0073) ebreakSeen = 1'b1;
        modelPc = expected.nextPc;
        sinceCommit = 0;
        commitCount++;
      end
      if (halted === 1'b1 && !sawHalt) begin
        if (!ebreakSeen) protocolError("halted rose before ebreak committed");
        sawHalt = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_rvCpu.sv
// Testbench top: clock, reset, random program generator, instruction memory, DUT and checker
`default_nettype none
`include "rv_config.svh"

module tb_rvCpu import rvPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ProgLen = 200;
  localparam int CycleLimit = ProgLen * 4 + 100;
  localparam int Slots = 8;

  logic clk;
  logic rst;
  xlenT instrAddr;
  instrT instr;
  logic commitValid;
  commitT commit;
  logic halted;
  int valueErrors;
  int protocolErrors;
  int commitCount;
  int cycles;
  int seed;
  int pos;
  int pick;
  int skip;
  int slot;
  logic timedOut;
  instrT prog [ProgLen];
  xlenT progIdx;

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  // Combinational instruction memory, nop outside the program
  assign progIdx = (instrAddr - xlenT'(`RV_RESET_PC)) >> 2;
  assign instr = (progIdx < ProgLen) ? prog[progIdx] : 32'h0000_0013;

  rvCpu u_dut (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .commitValid(commitValid), .commit(commit), .halted(halted)
  );

  rvCommitChecker uCommitCheck (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .commitValid(commitValid), .commit(commit), .halted(halted),
    .valueErrors(valueErrors), .protocolErrors(protocolErrors), .commitCount(commitCount)
  );

  function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic instrT encR(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd,
                                 logic [6:0] op);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic instrT encI(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                 logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic instrT encS(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic instrT encB(logic [12:0] off, int rs2, int rs1, logic [2:0] f3);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic instrT encJ(logic [20:0] off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic instrT encU(logic [19:0] imm, int rd, logic [6:0] op);
    return {imm, 5'(rd), op};
  endfunction

  // Random register arithmetic, x30 and x31 stay reserved
  function automatic instrT randomAlu();
    logic [2:0] f3s [7];
    logic [2:0] f3;
    f3s = '{3'b000, 3'b001, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
    f3 = f3s[randBelow(7)];
    case (randBelow(5))
      0: return encR((f3 == 3'b000 && randBelow(2) == 1) ? 7'h20 : 7'h00,
                     randBelow(32), randBelow(32), f3, randBelow(30), 7'b0110011);
      1: return encI((f3 == 3'b001) ? {6'b0, 6'(randBelow(64))} : 12'($random(seed)),
                     randBelow(32), f3, randBelow(30), 7'b0010011);
      2: return encR(7'h00, randBelow(32), randBelow(32), 3'b000, randBelow(30), 7'b0111011);
      3: return encI(12'($random(seed)), randBelow(32), 3'b000, randBelow(30), 7'b0011011);
      default: return encU(20'($random(seed)), randBelow(30),
                           (randBelow(2) == 1) ? 7'b0110111 : 7'b0010111);
    endcase
  endfunction

  task automatic buildProgram();
    // Landing points of forward jumps, a jalr without its auipc would use a stale base
    bit isTarget [ProgLen];
    // Base register x31 points at the middle of data memory
    prog[0] = encU(20'd0, 31, 7'b0110111);
    prog[1] = encI(12'(`RV_DMEM_WORDS * 4), 31, 3'b000, 31, 7'b0010011);
    for (int r = 1; r <= Slots; r++) begin
      prog[2 * r] = encU(20'($random(seed)), r, 7'b0110111);
      prog[2 * r + 1] = encI(12'($random(seed)), r, 3'b000, r, 7'b0010011);
    end
    // Every slot holds known data before any load
    for (int s = 0; s < Slots; s++) begin
      prog[2 * Slots + 2 + s] = encS(12'(8 * s), s + 1, 31, 3'b011);
    end
    pos = 3 * Slots + 2;
    while (pos < ProgLen - 1) begin
      pick = randBelow(10);
      skip = randBelow(4);
      slot = randBelow(Slots);
      if (pick < 4) begin
        prog[pos] = randomAlu();
      end else if (pick == 4) begin
        prog[pos] = (randBelow(2) == 1) ?
          encI(12'(8 * slot), 31, 3'b011, randBelow(30), 7'b0000011) :
          encI(12'(8 * slot + 4 * randBelow(2)), 31, 3'b010, randBelow(30), 7'b0000011);
      end else if (pick == 5) begin
        prog[pos] = (randBelow(2) == 1) ?
          encS(12'(8 * slot), randBelow(30), 31, 3'b011) :
          encS(12'(8 * slot + 4 * randBelow(2)), randBelow(30), 31, 3'b010);
      end else if (pick < 8 && pos + 1 + skip < ProgLen) begin
        pick = randBelow(6);
        prog[pos] = encB(13'(4 * (skip + 1)), randBelow(32), randBelow(32),
                         (pick < 2) ? 3'(pick) : 3'(pick + 2));
        isTarget[pos + 1 + skip] = 1'b1;
      end else if (pick == 8 && pos + 1 + skip < ProgLen) begin
        prog[pos] = encJ(21'(4 * (skip + 1)), randBelow(30));
        isTarget[pos + 1 + skip] = 1'b1;
      end else if (pick == 9 && pos + 2 + skip < ProgLen && !isTarget[pos + 1]) begin
        // auipc then jalr forward over up to three instructions
        prog[pos] = encU(20'd0, 30, 7'b0010111);
        pos++;
        prog[pos] = encI(12'(8 + 4 * skip), 30, 3'b000, randBelow(30), 7'b1100111);
        isTarget[pos + 1 + skip] = 1'b1;
      end else begin
        prog[pos] = randomAlu();
      end
      pos++;
    end
    prog[ProgLen - 1] = 32'h0010_0073;
  endtask

  initial begin
    seed = 32'h7f78_8022;
    rst = 1'b1;
    cycles = 0;
    timedOut = 1'b0;
    buildProgram();
    repeat (4) @(posedge clk);
    #2 rst = 1'b0;
    while (halted !== 1'b1 && cycles < CycleLimit) @(posedge clk);
    if (halted !== 1'b1) begin
      timedOut = 1'b1;
      $display("Timeout: core did not halt within %0d cycles", CycleLimit);
    end else begin
      repeat (20) @(posedge clk);
    end
    $display("Errors: value %0d, protocol %0d, timeout %0d, commits seen %0d",
             valueErrors, protocolErrors, timedOut, commitCount);
    if (!timedOut && valueErrors == 0 && protocolErrors == 0 && commitCount > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/rvPkg.sv
hdl/rvDecode.sv
hdl/rvRegFile.sv
hdl/rvAlu.sv
hdl/rvBranchUnit.sv
hdl/rvDataMem.sv
hdl/rvControl.sv
hdl/rvCpu.sv
bench/rvCommitChecker.sv
bench/tb_rvCpu.sv

//--- Bender.yml
package:
  name: rvcpu

export_include_dirs:
  - hdl

sources:
  - hdl/rvPkg.sv
  - hdl/rvDecode.sv
  - hdl/rvRegFile.sv
  - hdl/rvAlu.sv
  - hdl/rvBranchUnit.sv
  - hdl/rvDataMem.sv
  - hdl/rvControl.sv
  - hdl/rvCpu.sv
  - target: test
    files:
      - bench/rvCommitChecker.sv
      - bench/tb_rvCpu.sv
